//--- files.f
+incdir+hdl
hdl/lsu_bus_pkg.sv
hdl/lsu_op_pkg.sv
hdl/lsu_decode.sv
hdl/lsu_execute.sv
hdl/lsu_result.sv
hdl/lsu_top.sv
bench/lsu_clock_gen.sv
bench/lsu_assert.sv
bench/lsu_tb.sv

//--- Bender.yml
package:
  name: lsu

export_include_dirs:
  - hdl

sources:
  - hdl/lsu_bus_pkg.sv
  - hdl/lsu_op_pkg.sv
  - hdl/lsu_decode.sv
  - hdl/lsu_execute.sv
  - hdl/lsu_result.sv
  - hdl/lsu_top.sv
  - target: simulation
    files:
      - bench/lsu_clock_gen.sv
      - bench/lsu_assert.sv
      - bench/lsu_tb.sv

//--- bench/lsu_tb.sv
// load/store stage testbench

`timescale 1ns/100ps

`include "lsu_consts.svh"

module lsu_tb import lsu_op_pkg::*, lsu_bus_pkg::*; ();

  // 14 stores, 28 loads, 3 no-memory, 40 back-to-back
  localparam int n_ops = 85;
  localparam int timeout_cycles = n_ops * 40 + 16;

  logic clock;
  logic reset;
  logic in_valid_i, load_i, store_i, unsigned_i, reg_en_i;
  access_size_t size_i;
  wb_sel_t wb_sel_i;
  word_t addr_i, store_data_i, src2_i, pc_i;
  reg_idx_t rd_i;
  logic in_ready_o, out_valid_o, reg_en_o, busy_o;
  word_t wd_o;
  reg_idx_t rd_o;
  logic ar_valid_o, ar_ready_i, r_valid_i, r_ready_o;
  bus_addr_t ar_addr_o, aw_addr_o;
  bus_data_t r_data_i, w_data_o;
  bus_strb_t w_strb_o;
  logic aw_valid_o, aw_ready_i, w_valid_o, w_ready_i, b_valid_i, b_ready_o;

  int cycle;
  int errors;
  int issued;
  int seen;
  int ready_drops;
  word_t exp_wd_q[$];
  reg_idx_t exp_rd_q[$];
  logic exp_en_q[$];
  int exp_lat_q[$];
  bus_strb_t exp_strb_q[$];
  bus_data_t exp_wdata_q[$];
  bus_addr_t exp_raddr_q[$];
  bus_addr_t exp_waddr_q[$];
  bit [63:0] mem [bit [28:0]];
  logic [7:0] ref_mem [bit [31:0]];
  bus_addr_t rd_addr, wr_addr;
  bus_data_t wr_data;
  bus_strb_t wr_strb;

  lsu_clock_gen u_clock_gen (.clock_o(clock), .reset_o(reset));

  lsu_top u_dut (
    .clock(clock), .reset(reset),
    .in_valid_i(in_valid_i), .load_i(load_i), .store_i(store_i),
    .unsigned_i(unsigned_i), .size_i(size_i), .wb_sel_i(wb_sel_i),
    .addr_i(addr_i), .store_data_i(store_data_i), .src2_i(src2_i),
    .pc_i(pc_i), .rd_i(rd_i), .reg_en_i(reg_en_i), .in_ready_o(in_ready_o),
    .out_valid_o(out_valid_o), .wd_o(wd_o), .rd_o(rd_o),
    .reg_en_o(reg_en_o), .busy_o(busy_o),
    .ar_valid_o(ar_valid_o), .ar_addr_o(ar_addr_o), .ar_ready_i(ar_ready_i),
    .r_valid_i(r_valid_i), .r_data_i(r_data_i), .r_ready_o(r_ready_o),
    .aw_valid_o(aw_valid_o), .aw_addr_o(aw_addr_o), .aw_ready_i(aw_ready_i),
    .w_valid_o(w_valid_o), .w_data_o(w_data_o), .w_strb_o(w_strb_o),
    .w_ready_i(w_ready_i), .b_valid_i(b_valid_i), .b_ready_o(b_ready_o)
  );

  always @(posedge clock) cycle <= cycle + 1;

  // memory content before any store, depends on every address bit
  function automatic logic [7:0] fill_byte(input bit [31:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'hc3;
  endfunction

  function automatic bus_data_t read_beat(input bus_addr_t a);
    bus_data_t beat;
    if (mem.exists(a[31:3])) begin
      return mem[a[31:3]];
    end
    for (int k = 0; k < 8; k++) begin
      beat[8*k +: 8] = fill_byte({a[31:3], 3'(k)});
    end
    return beat;
  endfunction

  function automatic logic [7:0] known_byte(input bit [31:0] a);
    return ref_mem.exists(a) ? ref_mem[a] : fill_byte(a);
  endfunction

  // expected write-back value, ref memory follows each store
  function automatic word_t ref_wd(input logic ld, input logic st, input logic uns,
                                   input int sz, input int sel, input word_t addr,
                                   input word_t sdata, input word_t src2, input word_t pc);
    int n;
    word_t v;
    n = 1 << sz;
    v = '0;
    if (st && !ld) begin
      for (int k = 0; k < n; k++) begin
        ref_mem[addr + k] = sdata[8*k +: 8];
      end
    end
    for (int k = 0; k < n; k++) begin
      v[8*k +: 8] = known_byte(addr + k);
    end
    if (!uns && n < 4 && v[8*n-1]) begin
      v = v | (32'hffff_ffff << (8 * n));
    end
    case (sel)
      0: return addr;
      1: return v;
      2: return pc + `LSU_PC_STEP;
      default: return src2;
    endcase
  endfunction

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge clock);
      #0.5;
    end
  endtask

  task automatic issue(input logic ld, input logic st, input logic uns, input int sz,
                       input int sel, input word_t addr, input word_t sdata,
                       input word_t src2, input reg_idx_t rd, input logic en,
                       input bit check_lat);
    word_t pc;
    bus_strb_t strb;
    pc = 32'h1000 + 4 * issued;
    load_i = ld;
    store_i = st;
    unsigned_i = uns;
    size_i = access_size_t'(sz[1:0]);
    wb_sel_i = wb_sel_t'(sel[1:0]);
    addr_i = addr;
    store_data_i = sdata;
    src2_i = src2;
    pc_i = pc;
    rd_i = rd;
    reg_en_i = en;
    in_valid_i = 1'b1;
    while (!in_ready_o) begin
      ready_drops++;
      wait_cycles(1);
    end
    wait_cycles(1);
    // accepted at the edge just passed
    exp_wd_q.push_back(ref_wd(ld, st, uns, sz, sel, addr, sdata, src2, pc));
    exp_rd_q.push_back(rd);
    exp_en_q.push_back(en);
    exp_lat_q.push_back(check_lat ? cycle : -1);
    if (ld) begin
      exp_raddr_q.push_back(addr);
    end
    if (st && !ld) begin
      strb = (sz == 0) ? 8'h01 : (sz == 1) ? 8'h03 : 8'h0f;
      exp_strb_q.push_back(strb << addr[2:0]);
      exp_wdata_q.push_back(64'(sdata & ~(32'hffff_ffff << (8 << sz))) << (8 * addr[2:0]));
      exp_waddr_q.push_back(addr);
    end
    issued++;
    in_valid_i = 1'b0;
  endtask

  // read side of the memory
  initial begin
    forever begin
      @(posedge clock);
      #0.5;
      if (ar_valid_o) begin
        wait_cycles($urandom % 4);
        ar_ready_i = 1'b1;
        rd_addr = ar_addr_o;
        wait_cycles(1);
        ar_ready_i = 1'b0;
        check_level("ar_valid_o", ar_valid_o, 1'b0);
        if (exp_raddr_q.size() == 0) begin
          errors++;
          $display("read address seen with no load outstanding");
        end else begin
          if (rd_addr !== exp_raddr_q[0]) begin
            errors++;
            $display("CHECK FAILED ar_addr_o got %h expected %h", rd_addr, exp_raddr_q[0]);
          end
          void'(exp_raddr_q.pop_front());
        end
        wait_cycles($urandom % 4);
        r_data_i = read_beat(rd_addr);
        r_valid_i = 1'b1;
        check_level("r_ready_o", r_ready_o, 1'b1);
        wait_cycles(1);
        r_valid_i = 1'b0;
      end
    end
  end

  // write side, address and data accepted independently
  initial begin
    forever begin
      @(posedge clock);
      #0.5;
      if (aw_valid_o) begin
        fork
          begin
            wait_cycles($urandom % 4);
            aw_ready_i = 1'b1;
            wr_addr = aw_addr_o;
            wait_cycles(1);
            aw_ready_i = 1'b0;
            check_level("aw_valid_o", aw_valid_o, 1'b0);
          end
          begin
            wait_cycles($urandom % 4);
            w_ready_i = 1'b1;
            check_level("w_valid_o", w_valid_o, 1'b1);
            wr_data = w_data_o;
            wr_strb = w_strb_o;
            wait_cycles(1);
            w_ready_i = 1'b0;
            check_level("w_valid_o", w_valid_o, 1'b0);
          end
        join
        if (exp_strb_q.size() == 0) begin
          errors++;
          $display("write beat seen with no store outstanding");
        end else begin
          if (wr_addr !== exp_waddr_q[0]) begin
            errors++;
            $display("CHECK FAILED aw_addr_o got %h expected %h", wr_addr, exp_waddr_q[0]);
          end
          if (wr_strb !== exp_strb_q[0]) begin
            errors++;
            $display("CHECK FAILED w_strb_o got %h expected %h", wr_strb, exp_strb_q[0]);
          end
          if (wr_data !== exp_wdata_q[0]) begin
            errors++;
            $display("CHECK FAILED w_data_o got %h expected %h", wr_data, exp_wdata_q[0]);
          end
          void'(exp_waddr_q.pop_front());
          void'(exp_strb_q.pop_front());
          void'(exp_wdata_q.pop_front());
        end
        mem[wr_addr[31:3]] = read_beat(wr_addr);
        for (int k = 0; k < 8; k++) begin
          if (wr_strb[k]) begin
            mem[wr_addr[31:3]][8*k +: 8] = wr_data[8*k +: 8];
          end
        end
        wait_cycles($urandom % 4);
        b_valid_i = 1'b1;
        check_level("b_ready_o", b_ready_o, 1'b1);
        wait_cycles(1);
        b_valid_i = 1'b0;
      end
    end
  end

  // compare each write-back in order
  always @(negedge clock) begin : compare
    word_t e_wd;
    int e_lat;
    if (!reset && out_valid_o) begin
      if (exp_wd_q.size() == 0) begin
        errors++;
        $display("out_valid_o pulsed with no request outstanding");
      end else begin
        e_wd = exp_wd_q.pop_front();
        e_lat = exp_lat_q.pop_front();
        if (wd_o !== e_wd) begin
          errors++;
          $display("CHECK FAILED wd_o got %h expected %h", wd_o, e_wd);
        end
        if (rd_o !== exp_rd_q[0]) begin
          errors++;
          $display("CHECK FAILED rd_o got %h expected %h", rd_o, exp_rd_q[0]);
        end
        if (reg_en_o !== exp_en_q[0]) begin
          errors++;
          $display("CHECK FAILED reg_en_o got %h expected %h", reg_en_o, exp_en_q[0]);
        end
        void'(exp_rd_q.pop_front());
        void'(exp_en_q.pop_front());
        if (e_lat >= 0 && cycle != e_lat) begin
          errors++;
          $display("no-memory request did not finish one cycle after acceptance");
        end
      end
      seen++;
    end
  end

  initial begin
    wait (cycle >= timeout_cycles);
    $display("timeout after %0d cycles with %0d of %0d results", cycle, seen, issued);
    $display("Test FAILED");
    $finish;
  end

  initial begin : stimulus
    int sz;
    int kind;
    int sel;
    word_t a;
    void'($urandom(32'hf5b9_4a4c));
    {in_valid_i, load_i, store_i, unsigned_i, reg_en_i} = '0;
    size_i = size_byte;
    wb_sel_i = wb_alu;
    {addr_i, store_data_i, src2_i, pc_i} = '0;
    rd_i = '0;
    {ar_ready_i, r_valid_i, aw_ready_i, w_ready_i, b_valid_i} = '0;
    r_data_i = '0;
    wait_cycles(8);
    // control outputs held at their reset levels
    check_level("out_valid_o", out_valid_o, 1'b0);
    check_level("ar_valid_o", ar_valid_o, 1'b0);
    check_level("aw_valid_o", aw_valid_o, 1'b0);
    check_level("w_valid_o", w_valid_o, 1'b0);
    check_level("r_ready_o", r_ready_o, 1'b0);
    check_level("b_ready_o", b_ready_o, 1'b0);
    check_level("busy_o", busy_o, 1'b0);
    check_level("in_ready_o", in_ready_o, 1'b1);
    wait (!reset);
    wait_cycles(2);
    // stores at every aligned offset, then loads back
    for (sz = 0; sz < 3; sz++) begin
      for (int off = 0; off < 8; off += (1 << sz)) begin
        issue(0, 1, 0, sz, 0, 32'h100 + off, $urandom, 0, 0, 0, 0);
      end
    end
    for (sz = 0; sz < 3; sz++) begin
      for (int off = 0; off < 8; off += (1 << sz)) begin
        issue(1, 0, 0, sz, 1, 32'h100 + off, 0, 0, 5'd3 + off, 1, 0);
        issue(1, 0, 1, sz, 1, 32'h100 + off, 0, 0, 5'd4 + off, 1, 0);
      end
    end
    // no-memory requests from an idle stage
    for (sel = 0; sel < 4; sel++) begin
      if (sel != 1) begin
        while (busy_o) wait_cycles(1);
        issue(0, 0, 0, 2, sel, $urandom, 0, $urandom, 5'd20 + sel, 1, 1);
      end
    end
    ready_drops = 0;
    // back-to-back traffic through the skid buffer
    for (int i = 0; i < 40; i++) begin
      kind = $urandom % 3;
      sz = $urandom % 3;
      a = 32'h200 + ($urandom % 8) * 8 + (($urandom % 8) & ~((1 << sz) - 1));
      sel = (kind == 1) ? 1 : (($urandom % 3 == 0) ? 0 : 2 + $urandom % 2);
      issue(kind == 1, kind == 2, $urandom % 2, sz, sel, a, $urandom, $urandom,
            $urandom, kind != 2, 0);
    end
    while (seen < issued) wait_cycles(1);
    wait_cycles(4);
    if (ready_drops == 0) begin
      errors++;
      $display("in_ready_o never dropped during back-to-back requests");
    end
    if (seen != issued) begin
      errors++;
      $display("results %0d do not match accepted requests %0d", seen, issued);
    end
    if (exp_strb_q.size() != 0 || exp_raddr_q.size() != 0) begin
      errors++;
      $display("some accepted loads or stores never reached the bus");
    end
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- bench/lsu_assert.sv
// bus and pipeline protocol assertions

`timescale 1ns/100ps

module lsu_assert import lsu_bus_pkg::*; (
  input logic      clock,
  input logic      reset,
  input logic      ar_valid_o,
  input bus_addr_t ar_addr_o,
  input logic      ar_ready_i,
  input logic      aw_valid_o,
  input bus_addr_t aw_addr_o,
  input logic      aw_ready_i,
  input logic      w_valid_o,
  input bus_data_t w_data_o,
  input logic      w_ready_i,
  input logic      out_valid_o
);

  // valid and payload hold until the handshake
  ar_hold: assert property (@(posedge clock) disable iff (reset)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o))
    else $error("ar_valid_o dropped or ar_addr_o changed before handshake");

  aw_hold: assert property (@(posedge clock) disable iff (reset)
    aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_addr_o))
    else $error("aw_valid_o dropped or aw_addr_o changed before handshake");

  w_hold: assert property (@(posedge clock) disable iff (reset)
    w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_data_o))
    else $error("w_valid_o dropped or w_data_o changed before handshake");

  // one access at a time
  no_read_write_overlap: assert property (@(posedge clock) disable iff (reset)
    !(ar_valid_o && aw_valid_o))
    else $error("read and write address valid high together");

  out_pulse: assert property (@(posedge clock) disable iff (reset)
    out_valid_o |=> !out_valid_o)
    else $error("out_valid_o high for two cycles");

endmodule

bind lsu_top lsu_assert u_assert (
  .clock       (clock),
  .reset       (reset),
  .ar_valid_o  (ar_valid_o),
  .ar_addr_o   (ar_addr_o),
  .ar_ready_i  (ar_ready_i),
  .aw_valid_o  (aw_valid_o),
  .aw_addr_o   (aw_addr_o),
  .aw_ready_i  (aw_ready_i),
  .w_valid_o   (w_valid_o),
  .w_data_o    (w_data_o),
  .w_ready_i   (w_ready_i),
  .out_valid_o (out_valid_o)
);

//--- bench/lsu_clock_gen.sv
// testbench clock and reset

`timescale 1ns/100ps

module lsu_clock_gen (
  output logic clock_o,
  output logic reset_o
);

  // 4 ns period
  initial begin
    clock_o = 1'b0;
    forever #2 clock_o = ~clock_o;
  end

  // reset held for 16 rising edges
  initial begin
    reset_o = 1'b1;
    repeat (16) @(posedge clock_o);
    #0.5 reset_o = 1'b0;
  end

endmodule

//--- hdl/lsu_top.sv
// load/store stage top level

`timescale 1ns/100ps

module lsu_top import lsu_op_pkg::*, lsu_bus_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  // from execute stage
  input  logic         in_valid_i,
  input  logic         load_i,
  input  logic         store_i,
  input  logic         unsigned_i,
  input  access_size_t size_i,
  input  wb_sel_t      wb_sel_i,
  input  word_t        addr_i,
  input  word_t        store_data_i,
  input  word_t        src2_i,
  input  word_t        pc_i,
  input  reg_idx_t     rd_i,
  input  logic         reg_en_i,
  output logic         in_ready_o,
  // toward write-back
  output logic         out_valid_o,
  output word_t        wd_o,
  output reg_idx_t     rd_o,
  output logic         reg_en_o,
  output logic         busy_o,
  // memory bus
  output logic         ar_valid_o,
  output bus_addr_t    ar_addr_o,
  input  logic         ar_ready_i,
  input  logic         r_valid_i,
  input  bus_data_t    r_data_i,
  output logic         r_ready_o,
  output logic         aw_valid_o,
  output bus_addr_t    aw_addr_o,
  input  logic         aw_ready_i,
  output logic         w_valid_o,
  output bus_data_t    w_data_o,
  output bus_strb_t    w_strb_o,
  input  logic         w_ready_i,
  input  logic         b_valid_i,
  output logic         b_ready_o
);

  logic         take;
  logic         load_capture;
  logic         busy_state;
  logic         req_valid;
  req_kind_t    req_kind;
  bus_addr_t    req_addr;
  bus_data_t    req_wdata;
  bus_strb_t    req_wstrb;
  logic         req_unsigned;
  access_size_t req_size;
  wb_sel_t      req_wb_sel;
  word_t        req_alu;
  word_t        req_src2;
  word_t        req_pc;
  reg_idx_t     req_rd;
  logic         req_reg_en;

  lsu_decode u_decode (
    .clock          (clock),
    .reset          (reset),
    .in_valid_i     (in_valid_i),
    .load_i         (load_i),
    .store_i        (store_i),
    .unsigned_i     (unsigned_i),
    .size_i         (size_i),
    .wb_sel_i       (wb_sel_i),
    .addr_i         (addr_i),
    .store_data_i   (store_data_i),
    .src2_i         (src2_i),
    .pc_i           (pc_i),
    .rd_i           (rd_i),
    .reg_en_i       (reg_en_i),
    .take_i         (take),
    .in_ready_o     (in_ready_o),
    .req_valid_o    (req_valid),
    .req_kind_o     (req_kind),
    .req_addr_o     (req_addr),
    .req_wdata_o    (req_wdata),
    .req_wstrb_o    (req_wstrb),
    .req_unsigned_o (req_unsigned),
    .req_size_o     (req_size),
    .req_wb_sel_o   (req_wb_sel),
    .req_alu_o      (req_alu),
    .req_src2_o     (req_src2),
    .req_pc_o       (req_pc),
    .req_rd_o       (req_rd),
    .req_reg_en_o   (req_reg_en)
  );

  lsu_execute u_execute (
    .clock          (clock),
    .reset          (reset),
    .req_valid_i    (req_valid),
    .req_kind_i     (req_kind),
    .req_addr_i     (req_addr),
    .req_wdata_i    (req_wdata),
    .req_wstrb_i    (req_wstrb),
    .take_o         (take),
    .load_capture_o (load_capture),
    .out_valid_o    (out_valid_o),
    .busy_state_o   (busy_state),
    .ar_valid_o     (ar_valid_o),
    .ar_addr_o      (ar_addr_o),
    .ar_ready_i     (ar_ready_i),
    .r_valid_i      (r_valid_i),
    .r_ready_o      (r_ready_o),
    .aw_valid_o     (aw_valid_o),
    .aw_addr_o      (aw_addr_o),
    .aw_ready_i     (aw_ready_i),
    .w_valid_o      (w_valid_o),
    .w_data_o       (w_data_o),
    .w_strb_o       (w_strb_o),
    .w_ready_i      (w_ready_i),
    .b_valid_i      (b_valid_i),
    .b_ready_o      (b_ready_o)
  );

  lsu_result u_result (
    .clock          (clock),
    .reset          (reset),
    .take_i         (take),
    .load_capture_i (load_capture),
    .r_data_i       (r_data_i),
    .req_addr_i     (req_addr),
    .req_unsigned_i (req_unsigned),
    .req_size_i     (req_size),
    .req_wb_sel_i   (req_wb_sel),
    .req_alu_i      (req_alu),
    .req_src2_i     (req_src2),
    .req_pc_i       (req_pc),
    .req_rd_i       (req_rd),
    .req_reg_en_i   (req_reg_en),
    .wd_o           (wd_o),
    .rd_o           (rd_o),
    .reg_en_o       (reg_en_o)
  );

  // a pending request counts as busy before execute picks it up
  assign busy_o = busy_state || req_valid;

endmodule

//--- hdl/lsu_result.sv
// load extraction and write-back select

`timescale 1ns/100ps

`include "lsu_consts.svh"

module lsu_result import lsu_op_pkg::*, lsu_bus_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         take_i,
  input  logic         load_capture_i,
  input  bus_data_t    r_data_i,
  input  bus_addr_t    req_addr_i,
  input  logic         req_unsigned_i,
  input  access_size_t req_size_i,
  input  wb_sel_t      req_wb_sel_i,
  input  word_t        req_alu_i,
  input  word_t        req_src2_i,
  input  word_t        req_pc_i,
  input  reg_idx_t     req_rd_i,
  input  logic         req_reg_en_i,
  output word_t        wd_o,
  output reg_idx_t     rd_o,
  output logic         reg_en_o
);

  bus_addr_t    addr_q;
  logic         unsigned_q;
  access_size_t size_q;
  wb_sel_t      wb_sel_q;
  word_t        alu_q;
  word_t        src2_q;
  word_t        pc_q;
  reg_idx_t     rd_q;
  logic         reg_en_q;
  bus_data_t    rdata_q;
  word_t        half_beat;
  logic [7:0]   load_byte;
  logic [15:0]  load_half;
  word_t        load_value;

  always_ff @(posedge clock) begin
    if (reset) begin
      reg_en_q <= 1'b0;
    end else if (take_i) begin
      reg_en_q <= req_reg_en_i;
    end
  end

  always_ff @(posedge clock) begin
    if (take_i) begin
      addr_q     <= req_addr_i;
      unsigned_q <= req_unsigned_i;
      size_q     <= req_size_i;
      wb_sel_q   <= req_wb_sel_i;
      alu_q      <= req_alu_i;
      src2_q     <= req_src2_i;
      pc_q       <= req_pc_i;
      rd_q       <= req_rd_i;
    end
    if (load_capture_i) begin
      rdata_q <= r_data_i;
    end
  end

  // bit 2 picks the word, low bits pick the lane inside it
  assign half_beat = addr_q[2] ? rdata_q[63:32] : rdata_q[31:0];
  assign load_byte = half_beat[{addr_q[1:0], 3'b000} +: 8];
  assign load_half = half_beat[{addr_q[1], 4'b0000} +: 16];

  always_comb begin
    case (size_q)
      size_byte: load_value = unsigned_q ? {24'b0, load_byte} : {{24{load_byte[7]}}, load_byte};
      size_half: load_value = unsigned_q ? {16'b0, load_half} : {{16{load_half[15]}}, load_half};
      default:   load_value = half_beat;
    endcase
  end

  always_comb begin
    case (wb_sel_q)
      wb_load: wd_o = load_value;
      wb_link: wd_o = pc_q + word_t'(`LSU_PC_STEP);
      wb_src2: wd_o = src2_q;
      default: wd_o = alu_q;
    endcase
  end

  assign rd_o     = rd_q;
  assign reg_en_o = reg_en_q;

endmodule

//--- hdl/lsu_execute.sv
// memory access state machine

`timescale 1ns/100ps

module lsu_execute import lsu_op_pkg::*, lsu_bus_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      req_valid_i,
  input  req_kind_t req_kind_i,
  input  bus_addr_t req_addr_i,
  input  bus_data_t req_wdata_i,
  input  bus_strb_t req_wstrb_i,
  output logic      take_o,
  output logic      load_capture_o,
  output logic      out_valid_o,
  output logic      busy_state_o,
  // read address channel
  output logic      ar_valid_o,
  output bus_addr_t ar_addr_o,
  input  logic      ar_ready_i,
  // read data channel
  input  logic      r_valid_i,
  output logic      r_ready_o,
  // write address channel
  output logic      aw_valid_o,
  output bus_addr_t aw_addr_o,
  input  logic      aw_ready_i,
  // write data channel
  output logic      w_valid_o,
  output bus_data_t w_data_o,
  output bus_strb_t w_strb_o,
  input  logic      w_ready_i,
  // write response channel
  input  logic      b_valid_i,
  output logic      b_ready_o
);

  access_state_t state_q;
  access_state_t state_d;
  logic          ar_valid_q;
  logic          aw_valid_q;
  logic          w_valid_q;
  logic          resp_ready_q;
  bus_addr_t     addr_q;
  bus_data_t     w_data_q;
  bus_strb_t     w_strb_q;
  logic          aw_clear;
  logic          w_clear;
  logic          r_xfer;
  logic          b_xfer;

  assign take_o = (state_q == st_idle) && req_valid_i;

  // a channel is clear once its handshake has happened, now or earlier
  assign aw_clear = !aw_valid_q || aw_ready_i;
  assign w_clear  = !w_valid_q || w_ready_i;
  assign r_xfer   = r_valid_i && resp_ready_q;
  assign b_xfer   = b_valid_i && resp_ready_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (req_valid_i) begin
          case (req_kind_i)
            kind_load:  state_d = st_read_addr;
            kind_store: state_d = st_write_req;
            default:    state_d = st_done;
          endcase
        end
      end
      st_read_addr: begin
        if (ar_valid_q && ar_ready_i) begin
          state_d = st_read_data;
        end
      end
      st_read_data: begin
        if (r_xfer) begin
          state_d = st_done;
        end
      end
      st_write_req: begin
        if (aw_clear && w_clear) begin
          state_d = st_write_resp;
        end
      end
      st_write_resp: begin
        if (b_xfer) begin
          state_d = st_done;
        end
      end
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // each valid falls on its own handshake
  always_ff @(posedge clock) begin
    if (reset) begin
      ar_valid_q <= 1'b0;
      aw_valid_q <= 1'b0;
      w_valid_q  <= 1'b0;
    end else begin
      if (take_o && req_kind_i == kind_load) begin
        ar_valid_q <= 1'b1;
      end else if (ar_ready_i) begin
        ar_valid_q <= 1'b0;
      end
      if (take_o && req_kind_i == kind_store) begin
        aw_valid_q <= 1'b1;
        w_valid_q  <= 1'b1;
      end else begin
        if (aw_ready_i) begin
          aw_valid_q <= 1'b0;
        end
        if (w_ready_i) begin
          w_valid_q <= 1'b0;
        end
      end
    end
  end

  // payload held from take until the next take
  always_ff @(posedge clock) begin
    if (take_o) begin
      addr_q   <= req_addr_i;
      w_data_q <= req_wdata_i;
      w_strb_q <= req_wstrb_i;
    end
  end

  // responses are always accepted once out of reset
  always_ff @(posedge clock) begin
    if (reset) begin
      resp_ready_q <= 1'b0;
    end else begin
      resp_ready_q <= 1'b1;
    end
  end

  assign ar_valid_o = ar_valid_q;
  assign ar_addr_o  = addr_q;
  assign aw_valid_o = aw_valid_q;
  assign aw_addr_o  = addr_q;
  assign w_valid_o  = w_valid_q;
  assign w_data_o   = w_data_q;
  assign w_strb_o   = w_strb_q;
  assign r_ready_o  = resp_ready_q;
  assign b_ready_o  = resp_ready_q;

  assign load_capture_o = (state_q == st_read_data) && r_xfer;

  // done lasts exactly one cycle
  assign out_valid_o  = (state_q == st_done);
  assign busy_state_o = (state_q != st_idle);

endmodule

//--- hdl/lsu_decode.sv
// request skid buffer and store steering

`timescale 1ns/100ps

module lsu_decode import lsu_op_pkg::*, lsu_bus_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         in_valid_i,
  input  logic         load_i,
  input  logic         store_i,
  input  logic         unsigned_i,
  input  access_size_t size_i,
  input  wb_sel_t      wb_sel_i,
  input  word_t        addr_i,
  input  word_t        store_data_i,
  input  word_t        src2_i,
  input  word_t        pc_i,
  input  reg_idx_t     rd_i,
  input  logic         reg_en_i,
  input  logic         take_i,
  output logic         in_ready_o,
  output logic         req_valid_o,
  output req_kind_t    req_kind_o,
  output bus_addr_t    req_addr_o,
  output bus_data_t    req_wdata_o,
  output bus_strb_t    req_wstrb_o,
  output logic         req_unsigned_o,
  output access_size_t req_size_o,
  output wb_sel_t      req_wb_sel_o,
  output word_t        req_alu_o,
  output word_t        req_src2_o,
  output word_t        req_pc_o,
  output reg_idx_t     req_rd_o,
  output logic         req_reg_en_o
);

  logic         buf_full_q;
  logic         buf_load_q;
  logic         buf_store_q;
  logic         buf_unsigned_q;
  access_size_t buf_size_q;
  wb_sel_t      buf_wb_sel_q;
  word_t        buf_addr_q;
  word_t        buf_store_data_q;
  word_t        buf_src2_q;
  word_t        buf_pc_q;
  reg_idx_t     buf_rd_q;
  logic         buf_reg_en_q;
  logic         fill;
  logic         sel_load;
  logic         sel_store;
  word_t        sel_addr;
  word_t        sel_store_data;
  bus_strb_t    strb_base;
  bus_data_t    data_base;

  // an arrival that execute cannot take this cycle parks in the buffer
  assign fill = in_valid_i && !buf_full_q && !take_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      buf_full_q <= 1'b0;
    end else if (fill) begin
      buf_full_q <= 1'b1;
    end else if (take_i) begin
      buf_full_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (fill) begin
      buf_load_q       <= load_i;
      buf_store_q      <= store_i;
      buf_unsigned_q   <= unsigned_i;
      buf_size_q       <= size_i;
      buf_wb_sel_q     <= wb_sel_i;
      buf_addr_q       <= addr_i;
      buf_store_data_q <= store_data_i;
      buf_src2_q       <= src2_i;
      buf_pc_q         <= pc_i;
      buf_rd_q         <= rd_i;
      buf_reg_en_q     <= reg_en_i;
    end
  end

  // buffered request is older, so it goes first
  assign sel_load       = buf_full_q ? buf_load_q       : load_i;
  assign sel_store      = buf_full_q ? buf_store_q      : store_i;
  assign sel_addr       = buf_full_q ? buf_addr_q       : addr_i;
  assign sel_store_data = buf_full_q ? buf_store_data_q : store_data_i;
  assign req_unsigned_o = buf_full_q ? buf_unsigned_q   : unsigned_i;
  assign req_size_o     = buf_full_q ? buf_size_q       : size_i;
  assign req_wb_sel_o   = buf_full_q ? buf_wb_sel_q     : wb_sel_i;
  assign req_src2_o     = buf_full_q ? buf_src2_q       : src2_i;
  assign req_pc_o       = buf_full_q ? buf_pc_q         : pc_i;
  assign req_rd_o       = buf_full_q ? buf_rd_q         : rd_i;
  assign req_reg_en_o   = buf_full_q ? buf_reg_en_q     : reg_en_i;

  assign in_ready_o  = !buf_full_q;
  assign req_valid_o = buf_full_q || in_valid_i;

  // load wins when both flags are set
  assign req_kind_o = sel_load  ? kind_load  :
                      sel_store ? kind_store : kind_none;

  assign req_addr_o = sel_addr;
  assign req_alu_o  = sel_addr;

  // store data and strobes start at lane 0, then move to the addressed lanes
  always_comb begin
    case (req_size_o)
      size_byte: begin
        strb_base = 8'h01;
        data_base = bus_data_t'(sel_store_data[7:0]);
      end
      size_half: begin
        strb_base = 8'h03;
        data_base = bus_data_t'(sel_store_data[15:0]);
      end
      default: begin
        strb_base = 8'h0f;
        data_base = bus_data_t'(sel_store_data);
      end
    endcase
  end

  assign req_wstrb_o = strb_base << sel_addr[2:0];
  assign req_wdata_o = data_base << {sel_addr[2:0], 3'b000};

endmodule

//--- hdl/lsu_op_pkg.sv
// load/store operation types

`include "lsu_consts.svh"

package lsu_op_pkg;

  // register value
  typedef logic [`LSU_XLEN-1:0] word_t;

  // destination register index
  typedef logic [`LSU_REG_IDX_W-1:0] reg_idx_t;

  // width of a memory access
  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } access_size_t;

  // source of the write-back value
  typedef enum logic [1:0] {
    wb_alu  = 2'd0,
    wb_load = 2'd1,
    wb_link = 2'd2,
    wb_src2 = 2'd3
  } wb_sel_t;

  // what a request does on the bus
  typedef enum logic [1:0] {
    kind_none  = 2'd0,
    kind_load  = 2'd1,
    kind_store = 2'd2
  } req_kind_t;

  // bus access sequencing
  typedef enum logic [2:0] {
    st_idle       = 3'd0,
    st_read_addr  = 3'd1,
    st_read_data  = 3'd2,
    st_write_req  = 3'd3,
    st_write_resp = 3'd4,
    st_done       = 3'd5
  } access_state_t;

endpackage

//--- hdl/lsu_bus_pkg.sv
// memory bus types

`include "lsu_consts.svh"

package lsu_bus_pkg;

  // byte address on the read and write address channels
  typedef logic [`LSU_ADDR_W-1:0] bus_addr_t;

  // one data beat on the read or write data channel
  typedef logic [`LSU_BUS_DATA_W-1:0] bus_data_t;

  // byte enables for one beat
  // bit n qualifies bits 8n+7:8n of the beat
  typedef logic [`LSU_STRB_W-1:0] bus_strb_t;

endpackage

//--- hdl/lsu_consts.svh
// load/store stage constants

`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// register file width of the RV32 core
`define LSU_XLEN 32

// memory bus geometry
`define LSU_BUS_DATA_W 64
`define LSU_ADDR_W 32

// one strobe per byte lane of the data beat
`define LSU_STRB_W 8

// destination register index
`define LSU_REG_IDX_W 5

// link value is the address of the next instruction
`define LSU_PC_STEP 4

`endif
